/* Makefile */
VERILATOR := verilator
TOP := tb_top
FILELIST := files.f
FLAGS := --timing --timescale 1ns/100ps
OBJ_DIR := obj_dir
LOG := sim.log

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@grep -q "TESTBENCH PASSED" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* files.f */
hdl/iomem_pkg.sv
hdl/board_pkg.sv
hdl/iomem_if.sv
hdl/por_reset.sv
hdl/iomem_decode.sv
hdl/gpio_regs.sv
hdl/io_top.sv
verif/io_checker.sv
verif/tb_top.sv

/* hdl/board_pkg.sv */
/*
 * address map and board constants of the io subsystem
 * decode, gpio block and top level read their defaults from here
 */

package board_pkg;

	// page byte of the gpio block
	// every other page is answered by the decode stage
	localparam logic [7:0] GPIO_PAGE = 8'h03;

	// word offsets inside the gpio page
	// output reg at byte 0, input pins at byte 4
	localparam int unsigned GPIO_OUT_OFS = 0;
	localparam int unsigned GPIO_IN_OFS = 1;

	// led bank on the board, fed from the output register
	localparam int unsigned LED_W = 8;

	// input pins, read-only through the input register
	localparam int unsigned GPIO_IN_W = 8;

	// reset stretch counter width
	// internal reset held for 2**6-1 cycles
	localparam int unsigned POR_CNT_W = 6;

endpackage

/* hdl/gpio_regs.sv */
/*
 * gpio register block behind the decode stage
 * word 0 is a byte-strobed output register driving the leds
 * word 1 reads the synchronized input pins
 */

module gpio_regs #(
	parameter int unsigned IN_W = 8
) (
	input logic clk,
	input logic rst_n,
	iomem_if.slave bus,
	input logic [IN_W-1:0] gpio_in,
	output logic [board_pkg::LED_W-1:0] leds
);

	localparam int unsigned DATA_W = iomem_pkg::DATA_W;
	// word offset field below the page byte
	localparam int unsigned OFS_W = iomem_pkg::PAGE_LO - 2;

	logic accept;
	logic [OFS_W-1:0] word_ofs;
	logic out_sel;
	logic in_sel;
	logic [DATA_W-1:0] rd_val;

	// output register and input synchronizer
	logic [DATA_W-1:0] gpio_out;
	logic [IN_W-1:0] in_meta;
	logic [IN_W-1:0] in_sync;

	// page already matched upstream
	assign word_ofs = bus.addr[iomem_pkg::PAGE_LO-1:2];
	assign out_sel = word_ofs == OFS_W'(board_pkg::GPIO_OUT_OFS);
	assign in_sel = word_ofs == OFS_W'(board_pkg::GPIO_IN_OFS);

	// held valid ignored during our own ready pulse
	assign accept = bus.valid && !bus.ready;

	// two flops on the pins
	always_ff @(posedge clk) begin
		in_meta <= gpio_in;
		in_sync <= in_meta;
	end

	// pre-write value of the addressed word
	// other offsets read as zero
	always_comb begin
		rd_val = '0;
		if (out_sel) begin
			rd_val = gpio_out;
		end else if (in_sel) begin
			rd_val = DATA_W'(in_sync);
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			bus.ready <= 1'b0;
			gpio_out <= '0;
		end else begin
			// ready is a single-cycle pulse
			bus.ready <= accept;
			// byte lanes where the strobe is set
			// input word and unused offsets ignore writes
			if (accept && out_sel) begin
				for (int i = 0; i < iomem_pkg::STRB_W; i++) begin
					if (bus.wstrb[i]) begin
						gpio_out[8*i +: 8] <= bus.wdata[8*i +: 8];
					end
				end
			end
		end
	end

	// read data captured on the same edge as ready
	always_ff @(posedge clk) begin
		if (accept) begin
			bus.rdata <= rd_val;
		end
	end

	assign leds = gpio_out[board_pkg::LED_W-1:0];

endmodule

/* hdl/io_top.sv */
/*
 * io subsystem top level for a soft-cpu board
 * cpu iomem port in, leds and gpio pins out
 * stretched reset -> decode stage -> gpio registers
 */

module io_top #(
	parameter int unsigned POR_CNT_W = board_pkg::POR_CNT_W
) (
	input logic clk,
	input logic resetn,
	input logic iomem_valid,
	input logic [iomem_pkg::STRB_W-1:0] iomem_wstrb,
	input logic [iomem_pkg::ADDR_W-1:0] iomem_addr,
	input logic [iomem_pkg::DATA_W-1:0] iomem_wdata,
	input logic [board_pkg::GPIO_IN_W-1:0] gpio_in,
	output logic iomem_ready,
	output logic [iomem_pkg::DATA_W-1:0] iomem_rdata,
	output logic [board_pkg::LED_W-1:0] leds
);

	// internal reset after the stretch
	logic rst_n;

	// decode stage to gpio block
	iomem_if gpio_bus ();

	por_reset #(
		.CNT_W(POR_CNT_W)
	) por0 (
		.clk(clk),
		.resetn(resetn),
		.rst_n(rst_n)
	);

	// stage 1, page decode and unmapped replies
	iomem_decode dec0 (
		.clk(clk),
		.rst_n(rst_n),
		.req_valid(iomem_valid),
		.req_wstrb(iomem_wstrb),
		.req_addr(iomem_addr),
		.req_wdata(iomem_wdata),
		.req_ready(iomem_ready),
		.req_rdata(iomem_rdata),
		.gpio_bus(gpio_bus.master)
	);

	// stage 2, gpio registers
	gpio_regs #(
		.IN_W(board_pkg::GPIO_IN_W)
	) gpio0 (
		.clk(clk),
		.rst_n(rst_n),
		.bus(gpio_bus.slave),
		.gpio_in(gpio_in),
		.leds(leds)
	);

endmodule

/* hdl/iomem_decode.sv */
/*
 * first pipeline stage of the iomem port
 * registers a request, forwards gpio page hits on gpio_bus
 * and answers all other pages itself (writes dropped, reads zero)
 */

module iomem_decode (
	input logic clk,
	input logic rst_n,
	input logic req_valid,
	input logic [iomem_pkg::STRB_W-1:0] req_wstrb,
	input logic [iomem_pkg::ADDR_W-1:0] req_addr,
	input logic [iomem_pkg::DATA_W-1:0] req_wdata,
	output logic req_ready,
	output logic [iomem_pkg::DATA_W-1:0] req_rdata,
	iomem_if.master gpio_bus
);

	// one request in flight, from accept until its ready pulse
	logic busy;
	logic accept;
	logic page_hit;

	// gpio side request
	logic gpio_valid;
	logic [iomem_pkg::STRB_W-1:0] wstrb_q;
	logic [iomem_pkg::ADDR_W-1:0] addr_q;
	logic [iomem_pkg::DATA_W-1:0] wdata_q;

	// local reply for unmapped pages
	// arm on accept, ready one edge later
	logic umap_arm;
	logic umap_ready;

	// held valid is masked while busy
	assign accept = req_valid && !busy;
	assign page_hit = req_addr[iomem_pkg::PAGE_HI:iomem_pkg::PAGE_LO] == board_pkg::GPIO_PAGE;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			busy <= 1'b0;
			gpio_valid <= 1'b0;
			umap_arm <= 1'b0;
			umap_ready <= 1'b0;
		end else begin
			umap_ready <= umap_arm;
			umap_arm <= 1'b0;
			if (accept) begin
				busy <= 1'b1;
				gpio_valid <= page_hit;
				umap_arm <= !page_hit;
			end else begin
				// drop valid in the cycle after the gpio ready
				if (gpio_bus.ready) begin
					gpio_valid <= 1'b0;
				end
				// response returned, free for the next request
				if (req_ready) begin
					busy <= 1'b0;
				end
			end
		end
	end

	// request payload, only read while gpio_valid is high
	always_ff @(posedge clk) begin
		if (accept) begin
			wstrb_q <= req_wstrb;
			addr_q <= req_addr;
			wdata_q <= req_wdata;
		end
	end

	assign gpio_bus.valid = gpio_valid;
	assign gpio_bus.wstrb = wstrb_q;
	assign gpio_bus.addr = addr_q;
	assign gpio_bus.wdata = wdata_q;

	// response back to the top, no extra register
	// unmapped reads return zero
	assign req_ready = gpio_bus.ready || umap_ready;
	assign req_rdata = gpio_bus.ready ? gpio_bus.rdata : '0;

endmodule

/* hdl/iomem_if.sv */
/*
 * one iomem request/response channel between two pipeline stages
 * master holds valid and fields until it sees the one-cycle ready pulse
 */

interface iomem_if;

	// request side
	logic valid;
	logic [iomem_pkg::STRB_W-1:0] wstrb;
	logic [iomem_pkg::ADDR_W-1:0] addr;
	logic [iomem_pkg::DATA_W-1:0] wdata;

	// response side
	// rdata only meaningful while ready is high
	logic ready;
	logic [iomem_pkg::DATA_W-1:0] rdata;

	// request issuer
	modport master (
		output valid,
		output wstrb,
		output addr,
		output wdata,
		input ready,
		input rdata
	);

	// responder
	modport slave (
		input valid,
		input wstrb,
		input addr,
		input wdata,
		output ready,
		output rdata
	);

endinterface

/* hdl/iomem_pkg.sv */
/*
 * sizes of the cpu-style iomem request port
 * shared by the interface, the decode stage and the top-level ports
 */

package iomem_pkg;

	// byte address from the cpu
	localparam int unsigned ADDR_W = 32;

	// one bus word per beat
	localparam int unsigned DATA_W = 32;

	// one strobe per data byte
	// all strobes clear means a read
	localparam int unsigned STRB_W = DATA_W / 8;

	// page byte at the top of the address
	// the decode stage routes on this field only
	localparam int unsigned PAGE_HI = 31;
	localparam int unsigned PAGE_LO = 24;

endpackage

/* hdl/por_reset.sv */
/*
 * stretches the external reset into the internal synchronous reset
 * rst_n rises only after 2**CNT_W-1 cycles of resetn high
 */

module por_reset #(
	parameter int unsigned CNT_W = 6
) (
	input logic clk,
	input logic resetn,
	output logic rst_n
);

	// stretch counter, saturates at all ones
	logic [CNT_W-1:0] cnt;
	logic cnt_full;

	assign cnt_full = &cnt;

	// restart on every external reset
	// count up while released, stop when full
	always_ff @(posedge clk) begin
		if (!resetn) begin
			cnt <= '0;
		end else if (!cnt_full) begin
			cnt <= cnt + 1'b1;
		end
	end

	// registered and of the counter bits
	// low one edge after resetn is seen low
	// high on the edge after the counter fills
	always_ff @(posedge clk) begin
		rst_n <= cnt_full;
	end

endmodule

/* verif/io_checker.sv */
/*
 * response monitor beside dut0
 * checks rdata, leds and ready latency on every ready pulse
 */

module io_checker (
	input logic clk,
	input logic iomem_valid,
	input logic iomem_ready,
	input logic [iomem_pkg::DATA_W-1:0] iomem_rdata,
	input logic [board_pkg::LED_W-1:0] leds,
	input int test_no,
	input logic [iomem_pkg::DATA_W-1:0] exp_rdata,
	input logic [board_pkg::LED_W-1:0] exp_leds,
	input int exp_lat,
	output int pass_cnt,
	output int fail_cnt
);

	timeunit 1ns;
	timeprecision 100ps;

	int n_pass = 0;
	int n_fail = 0;
	// request seen, ready not yet
	bit in_flight = 1'b0;
	// rising edges since valid was first seen
	int lat = 0;

	assign pass_cnt = n_pass;
	assign fail_cnt = n_fail;

	task automatic check_response();
		bit ok;
		ok = (iomem_rdata === exp_rdata) && (leds === exp_leds) && (lat == exp_lat);
		if (ok) begin
			n_pass++;
			$display("[PASS] test %0d rdata %h leds %h latency %0d",
				test_no, iomem_rdata, leds, lat);
		end else begin
			n_fail++;
			$display("[FAIL] %0t test %0d: rdata %h exp %h, leds %h exp %h, latency %0d exp %0d",
				$time, test_no, iomem_rdata, exp_rdata, leds, exp_leds, lat, exp_lat);
		end
	endtask

	// falling edge, dut outputs settled
	always @(negedge clk) begin
		if (in_flight) begin
			lat++;
			if (iomem_ready) begin
				in_flight = 1'b0;
				check_response();
			end
		end else if (iomem_ready) begin
			// second pulse or pulse during reset
			n_fail++;
			$display("error at %0t: ready pulse with no request in flight", $time);
		end else if (iomem_valid) begin
			in_flight = 1'b1;
			lat = 0;
		end
	end

endmodule

/* verif/iomem_golden.txt */
# test addr wstrb wdata gpio_in exp_rdata exp_leds
# all fields hex except test, exp_rdata is the pre-write value
1 03000000 0 00000000 00 00000000 00
2 03000000 f 12345678 00 00000000 78
3 03000000 0 00000000 11 12345678 78
4 03000000 1 aabbccdd 22 12345678 dd
5 03000000 6 11223344 33 123456dd dd
6 03000000 8 99000000 44 122233dd dd
7 03000000 0 00000000 55 992233dd dd
8 03000004 0 00000000 a5 000000a5 dd
9 03000004 f ffffffff a5 000000a5 dd
10 03000004 0 00000000 3c 0000003c dd
11 03000000 0 00000000 3c 992233dd dd
12 03000008 0 00000000 3c 00000000 dd
13 0300000c f deadbeef 3c 00000000 dd
14 02000000 0 00000000 3c 00000000 dd
15 00000000 f cafef00d 3c 00000000 dd
16 ff000000 f 01010101 3c 00000000 dd
17 03000000 0 00000000 3c 992233dd dd
18 03000000 3 0000a55a 3c 992233dd 5a
19 03000000 0 00000000 3c 9922a55a 5a
20 03000010 0 00000000 3c 00000000 5a
21 03400000 f 77777777 3c 00000000 5a
22 03000000 f 00000000 3c 9922a55a 00
23 03000000 0 00000000 ff 00000000 00
24 03000004 0 00000000 ff 000000ff 00
25 04000004 0 00000000 ff 00000000 00

/* verif/tb_top.sv */
/*
 * testbench top for the io subsystem
 * plays the cpu master from the golden transaction file
 * io_checker compares every response
 */

module tb_top;

	timeunit 1ns;
	timeprecision 100ps;

	localparam string GOLDEN_PATH = "verif/iomem_golden.txt";
	// edges from first valid sample to ready, one per register stage
	localparam int REQ_LAT = 2;
	// rst_n rises on edge STRETCH+1 after release, request accepted on the next
	localparam int STRETCH = (1 << board_pkg::POR_CNT_W) - 1;
	localparam int STRETCH_LAT = STRETCH + 1 + REQ_LAT;
	localparam int RST_TIMEOUT = 200;
	localparam int READY_TIMEOUT = 20;

	logic clk;
	logic resetn;
	logic iomem_valid;
	logic [iomem_pkg::STRB_W-1:0] iomem_wstrb;
	logic [iomem_pkg::ADDR_W-1:0] iomem_addr;
	logic [iomem_pkg::DATA_W-1:0] iomem_wdata;
	logic [board_pkg::GPIO_IN_W-1:0] gpio_in;
	logic iomem_ready;
	logic [iomem_pkg::DATA_W-1:0] iomem_rdata;
	logic [board_pkg::LED_W-1:0] leds;

	// expected values handed to the checker
	int test_no;
	logic [iomem_pkg::DATA_W-1:0] exp_rdata;
	logic [board_pkg::LED_W-1:0] exp_leds;
	int exp_lat;
	int pass_cnt;
	int fail_cnt;

	// current golden line
	int v_test;
	logic [iomem_pkg::ADDR_W-1:0] v_addr;
	logic [iomem_pkg::STRB_W-1:0] v_strb;
	logic [iomem_pkg::DATA_W-1:0] v_wdata;
	logic [board_pkg::GPIO_IN_W-1:0] v_gpio;
	logic [iomem_pkg::DATA_W-1:0] v_rdata;
	logic [board_pkg::LED_W-1:0] v_leds;

	int fd;
	int n_sent;
	bit aborted;
	logic [31:0] lcg_state;

	io_top #(
		.POR_CNT_W(board_pkg::POR_CNT_W)
	) dut0 (
		.clk(clk),
		.resetn(resetn),
		.iomem_valid(iomem_valid),
		.iomem_wstrb(iomem_wstrb),
		.iomem_addr(iomem_addr),
		.iomem_wdata(iomem_wdata),
		.gpio_in(gpio_in),
		.iomem_ready(iomem_ready),
		.iomem_rdata(iomem_rdata),
		.leds(leds)
	);

	io_checker chk0 (
		.clk(clk),
		.iomem_valid(iomem_valid),
		.iomem_ready(iomem_ready),
		.iomem_rdata(iomem_rdata),
		.leds(leds),
		.test_no(test_no),
		.exp_rdata(exp_rdata),
		.exp_leds(exp_leds),
		.exp_lat(exp_lat),
		.pass_cnt(pass_cnt),
		.fail_cnt(fail_cnt)
	);

	always #5 clk = ~clk;

	function automatic logic [31:0] lcg_next(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	// next data line, comment and blank lines skipped
	task automatic read_vector(output bit ok);
		string line;
		int n;
		bit eof;
		ok = 1'b0;
		eof = 1'b0;
		while (!ok && !eof) begin
			n = $fgets(line, fd);
			if (n == 0) begin
				eof = 1'b1;
			end else if (line.getc(0) != "#") begin
				n = $sscanf(line, "%d %h %h %h %h %h %h", v_test, v_addr, v_strb,
					v_wdata, v_gpio, v_rdata, v_leds);
				ok = (n == 7);
			end
		end
	endtask

	// drive one request, hold valid until ready, drop it the cycle after
	task automatic issue_request(input int limit, output bit seen);
		int cycles;
		cycles = 0;
		seen = 1'b0;
		test_no = v_test;
		exp_rdata = v_rdata;
		exp_leds = v_leds;
		iomem_addr = v_addr;
		iomem_wstrb = v_strb;
		iomem_wdata = v_wdata;
		iomem_valid = 1'b1;
		while (!seen && cycles < limit) begin
			@(posedge clk);
			#1;
			cycles++;
			seen = iomem_ready;
		end
		if (seen) begin
			@(posedge clk);
			#1;
			iomem_valid = 1'b0;
		end
		n_sent++;
	endtask

	task automatic run_vectors();
		bit ok;
		bit seen;
		int idle;
		read_vector(ok);
		if (!ok) begin
			$display("error: no transactions found in %s", GOLDEN_PATH);
			aborted = 1'b1;
		end else begin
			// pins of the first line set while in reset
			gpio_in = v_gpio;
			repeat (10) @(posedge clk);
			#1;
			resetn = 1'b1;
			// first request goes out with the release, inside the stretch
			exp_lat = STRETCH_LAT;
			issue_request(RST_TIMEOUT, seen);
			if (!seen) begin
				$display("timeout: internal reset never released, no ready for test %0d",
					v_test);
				aborted = 1'b1;
			end
			read_vector(ok);
			while (ok && !aborted) begin
				@(posedge clk);
				#1;
				gpio_in = v_gpio;
				// pins settle through the synchronizer
				repeat (4) @(posedge clk);
				lcg_state = lcg_next(lcg_state);
				idle = int'(lcg_state[17:16]);
				repeat (idle) @(posedge clk);
				#1;
				exp_lat = REQ_LAT;
				issue_request(READY_TIMEOUT, seen);
				if (!seen) begin
					$display("timeout: no ready within %0d cycles for test %0d",
						READY_TIMEOUT, v_test);
					aborted = 1'b1;
				end
				read_vector(ok);
			end
		end
	endtask

	initial begin
		clk = 1'b0;
		resetn = 1'b0;
		iomem_valid = 1'b0;
		iomem_wstrb = '0;
		iomem_addr = '0;
		iomem_wdata = '0;
		gpio_in = '0;
		test_no = 0;
		exp_rdata = '0;
		exp_leds = '0;
		exp_lat = REQ_LAT;
		n_sent = 0;
		aborted = 1'b0;
		lcg_state = 32'h890ec6c7;
		fd = $fopen(GOLDEN_PATH, "r");
		if (fd == 0) begin
			$display("error: cannot open %s", GOLDEN_PATH);
			aborted = 1'b1;
		end else begin
			run_vectors();
			$fclose(fd);
		end
		// let a stray ready show up before the verdict
		repeat (4) @(posedge clk);
		$display("tests sent %0d, passed %0d, failed %0d", n_sent, pass_cnt, fail_cnt);
		if (!aborted && fail_cnt == 0 && pass_cnt == n_sent) begin
			$display("TESTBENCH PASSED");
		end else begin
			$display("TESTBENCH FAILED");
		end
		$finish;
	end

endmodule
